/* verilog/ms_pkg.sv */
package ms_pkg;

    // Board limits
    localparam int GRID_MAX = 16;                 // Largest side in cells
    localparam int CELL_W   = 4;                  // Row / column index width
    localparam int COUNT_W  = 4;                  // Neighbor count, 0..8
    localparam int MINE_W   = 6;                  // Mine count, up to 63

    // Player difficulty choice, straight from the two level inputs
    typedef enum logic [1:0] {
        LVL_NONE   = 2'd0,                        // Nothing chosen yet
        LVL_EASY   = 2'd1,
        LVL_MEDIUM = 2'd2,
        LVL_HARD   = 2'd3
    } level_e;

    // Level select FSM
    typedef enum logic [1:0] {
        IDLE        = 2'b00,                      // Waiting for a level
        CHOSE_LEVEL = 2'b01,                      // One cycle, table loaded
        LOCKED      = 2'b11                       // Held until rst
    } sel_state_e;

    // Mine placer FSM
    typedef enum logic [1:0] {
        P_IDLE  = 2'd0,
        P_CLEAR = 2'd1,                           // Wipe map
        P_DRAW  = 2'd2,                           // One LFSR draw per cycle
        P_DONE  = 2'd3
    } place_state_e;

    // One bit per cell, index row*GRID_MAX + col
    typedef logic [GRID_MAX*GRID_MAX-1:0] mine_map_t;

endpackage

/* verilog/select_level.sv */
`timescale 1ns/1ns

module select_level import ms_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  level_e            level,
    output logic              cfg_valid,
    output logic [4:0]        grid_n,
    output logic [MINE_W-1:0] mine_count,
    output logic [9:0]        board_size,
    output logic [10:0]       board_xpos,
    output logic [10:0]       board_ypos,
    output logic [6:0]        cell_size
);

    sel_state_e        state, state_nxt;
    level_e            level_q;              // Sampled player choice
    logic              cfg_valid_nxt;
    logic [4:0]        grid_n_nxt;
    logic [MINE_W-1:0] mine_count_nxt;
    logic [9:0]        board_size_nxt;
    logic [10:0]       board_xpos_nxt;
    logic [10:0]       board_ypos_nxt;
    logic [6:0]        cell_size_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            level_q <= LVL_NONE;
            state   <= IDLE;
        end else begin
            level_q <= level;                // Input register, FSM acts one edge later
            state   <= state_nxt;
        end
    end

    always_comb begin
        case (state)
            IDLE:        state_nxt = (level_q != LVL_NONE) ? CHOSE_LEVEL : IDLE;
            CHOSE_LEVEL: state_nxt = LOCKED;
            LOCKED:      state_nxt = LOCKED;  // Only rst leaves
            default:     state_nxt = IDLE;
        endcase
    end

    // Next outputs, decoded from the next state
    always_comb begin
        cfg_valid_nxt  = 1'b0;
        grid_n_nxt     = grid_n;             // Hold by default
        mine_count_nxt = mine_count;
        board_size_nxt = board_size;
        board_xpos_nxt = board_xpos;
        board_ypos_nxt = board_ypos;
        cell_size_nxt  = cell_size;
        if (state_nxt == CHOSE_LEVEL) begin
            cfg_valid_nxt = 1'b1;            // Single strobe on entry
            case (level_q)
                LVL_HARD: begin
                    mine_count_nxt = 6'd60;
                    grid_n_nxt     = 5'd16;
                    board_size_nxt = 10'd640;
                    board_xpos_nxt = 11'd400;
                    board_ypos_nxt = 11'd130;
                    cell_size_nxt  = 7'd40;
                end
                LVL_MEDIUM: begin
                    mine_count_nxt = 6'd20;
                    grid_n_nxt     = 5'd10;
                    board_size_nxt = 10'd500;
                    board_xpos_nxt = 11'd470;
                    board_ypos_nxt = 11'd200;
                    cell_size_nxt  = 7'd50;
                end
                default: begin               // EASY, NONE cannot get here
                    mine_count_nxt = 6'd8;
                    grid_n_nxt     = 5'd8;
                    board_size_nxt = 10'd400;
                    board_xpos_nxt = 11'd520;
                    board_ypos_nxt = 11'd250;
                    cell_size_nxt  = 7'd50;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_valid  <= 1'b0;
            grid_n     <= '0;
            mine_count <= '0;
            board_size <= '0;
            board_xpos <= '0;
            board_ypos <= '0;
            cell_size  <= '0;
        end else begin
            cfg_valid  <= cfg_valid_nxt;
            grid_n     <= grid_n_nxt;
            mine_count <= mine_count_nxt;
            board_size <= board_size_nxt;
            board_xpos <= board_xpos_nxt;
            board_ypos <= board_ypos_nxt;
            cell_size  <= cell_size_nxt;
        end
    end

    // Config is issued once per reset
    a_cfg_single: assert property (@(posedge clk) disable iff (rst) cfg_valid |=> !cfg_valid)
        else $error("cfg_valid high two cycles in a row");

endmodule

/* verilog/mine_placer.sv */
`timescale 1ns/1ns

module mine_placer import ms_pkg::*; #(
    parameter int          MAX_GRID  = GRID_MAX,
    parameter logic [15:0] LFSR_SEED = 16'hACE1
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cfg_valid,
    input  logic [4:0]        grid_n,
    input  logic [MINE_W-1:0] mine_count,
    output mine_map_t         mine_map,
    output logic              placing,
    output logic              place_done
);

    place_state_e      state;
    logic [15:0]       lfsr;
    logic [15:0]       lfsr_nxt;
    logic [CELL_W-1:0] draw_row;             // Candidate cell from LFSR low bits
    logic [CELL_W-1:0] draw_col;
    logic [4:0]        lim;                  // Effective side length
    logic [MINE_W-1:0] placed;               // Mines set so far
    logic              in_grid;
    logic              hit;                  // Accepted draw
    logic              stray;                // Mine outside the board

    assign lim      = (grid_n > 5'(MAX_GRID)) ? 5'(MAX_GRID) : grid_n;
    // Galois form, taps 16,14,13,11
    assign lfsr_nxt = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
    assign draw_col = lfsr[CELL_W-1:0];
    assign draw_row = lfsr[2*CELL_W-1:CELL_W];
    assign in_grid  = ({1'b0, draw_row} < lim) && ({1'b0, draw_col} < lim);
    assign hit      = in_grid && !mine_map[int'(draw_row)*GRID_MAX + int'(draw_col)];

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= P_IDLE;
            placing    <= 1'b0;
            place_done <= 1'b0;
            placed     <= '0;
            lfsr       <= LFSR_SEED;
        end else begin
            place_done <= 1'b0;              // Strobe by default
            if (cfg_valid) begin
                state   <= P_CLEAR;          // Restart from any state
                placing <= 1'b1;
                placed  <= '0;
                lfsr    <= LFSR_SEED;        // Same board for the same seed
            end else begin
                case (state)
                    P_CLEAR: begin
                        if (mine_count == '0) begin
                            state      <= P_DONE;  // Nothing to draw
                            placing    <= 1'b0;
                            place_done <= 1'b1;
                        end else begin
                            state <= P_DRAW;
                        end
                    end
                    P_DRAW: begin
                        lfsr <= lfsr_nxt;    // New candidate every cycle
                        if (hit) begin
                            placed <= placed + MINE_W'(1);
                            if (placed + MINE_W'(1) == mine_count) begin
                                state      <= P_DONE;
                                placing    <= 1'b0;
                                place_done <= 1'b1;
                            end
                        end
                    end
                    default: begin
                        state <= state;      // IDLE and DONE wait for cfg
                    end
                endcase
            end
        end
    end

    // Map storage
    always_ff @(posedge clk) begin
        if (state == P_CLEAR) begin
            mine_map <= '0;
        end else if (state == P_DRAW && hit) begin
            mine_map[int'(draw_row)*GRID_MAX + int'(draw_col)] <= 1'b1;
        end
    end

    // Scan for any set bit past the configured side
    always_comb begin
        stray = 1'b0;
        for (int r = 0; r < GRID_MAX; r++) begin
            for (int c = 0; c < GRID_MAX; c++) begin
                if (mine_map[r*GRID_MAX + c] && (r >= int'(lim) || c >= int'(lim))) begin
                    stray = 1'b1;
                end
            end
        end
    end

    a_placed_bound: assert property (@(posedge clk) disable iff (rst) placed <= mine_count)
        else $error("placed count above mine_count");
    a_no_stray: assert property (@(posedge clk) disable iff (rst)
        (state inside {P_DRAW, P_DONE}) |-> !stray)
        else $error("mine set outside grid_n");

endmodule

/* verilog/neighbor_counter.sv */
`timescale 1ns/1ns

module neighbor_counter import ms_pkg::*; #(
    parameter int MAX_GRID = GRID_MAX
) (
    input  logic               clk,
    input  logic               rst,
    input  mine_map_t          mine_map,
    input  logic [4:0]         grid_n,
    input  logic               query_valid,
    input  logic [CELL_W-1:0]  query_row,
    input  logic [CELL_W-1:0]  query_col,
    output logic               result_valid,
    output logic               is_mine,
    output logic [COUNT_W-1:0] near_count
);

    logic [4:0]         lim;                 // Effective side length
    logic               mine_c;              // Flag of queried cell
    logic [COUNT_W-1:0] near_c;              // Sum before the register

    assign lim    = (grid_n > 5'(MAX_GRID)) ? 5'(MAX_GRID) : grid_n;
    assign mine_c = ({1'b0, query_row} < lim) && ({1'b0, query_col} < lim)
                    && mine_map[int'(query_row)*GRID_MAX + int'(query_col)];

    // 3x3 window around the query, centre excluded
    always_comb begin
        int r;
        int c;
        near_c = '0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                r = int'(query_row) + dr;
                c = int'(query_col) + dc;
                if (!(dr == 0 && dc == 0) && r >= 0 && c >= 0
                    && r < int'(lim) && c < int'(lim)) begin
                    near_c = near_c + COUNT_W'(mine_map[r*GRID_MAX + c]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= query_valid;     // Fixed one-cycle latency
        end
    end

    // Result payload, a new query each cycle is fine
    always_ff @(posedge clk) begin
        if (query_valid) begin
            is_mine    <= mine_c;
            near_count <= near_c;
        end
    end

    a_near_max: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> near_count <= COUNT_W'(8))
        else $error("near_count above 8");

endmodule

/* verilog/minesweeper_setup.sv */
`timescale 1ns/1ns

module minesweeper_setup import ms_pkg::*; #(
    parameter int          MAX_GRID  = 16,
    parameter logic [15:0] LFSR_SEED = 16'hACE1
) (
    input  logic               clk,
    input  logic               rst,
    input  level_e             level,
    input  logic               query_valid,
    input  logic [CELL_W-1:0]  query_row,
    input  logic [CELL_W-1:0]  query_col,
    output logic [4:0]         grid_n,
    output logic [9:0]         board_size,
    output logic [10:0]        board_xpos,
    output logic [10:0]        board_ypos,
    output logic [6:0]         cell_size,
    output logic [MINE_W-1:0]  mine_count,
    output logic               cfg_valid,
    output logic               placing,
    output logic               place_done,
    output logic               result_valid,
    output logic               is_mine,
    output logic [COUNT_W-1:0] near_count
);

    mine_map_t mine_map;                     // Placer to counter

    select_level select_level_i (
        .clk        (clk),
        .rst        (rst),
        .level      (level),
        .cfg_valid  (cfg_valid),
        .grid_n     (grid_n),
        .mine_count (mine_count),
        .board_size (board_size),
        .board_xpos (board_xpos),
        .board_ypos (board_ypos),
        .cell_size  (cell_size)
    );

    mine_placer #(
        .MAX_GRID  (MAX_GRID),
        .LFSR_SEED (LFSR_SEED)
    ) mine_placer_i (
        .clk        (clk),
        .rst        (rst),
        .cfg_valid  (cfg_valid),             // Starts placement
        .grid_n     (grid_n),
        .mine_count (mine_count),
        .mine_map   (mine_map),
        .placing    (placing),
        .place_done (place_done)
    );

    neighbor_counter #(
        .MAX_GRID (MAX_GRID)
    ) neighbor_counter_i (
        .clk          (clk),
        .rst          (rst),
        .mine_map     (mine_map),
        .grid_n       (grid_n),
        .query_valid  (query_valid),
        .query_row    (query_row),
        .query_col    (query_col),
        .result_valid (result_valid),
        .is_mine      (is_mine),
        .near_count   (near_count)
    );

endmodule

/* test/minesweeper_setup_tb.sv */
`timescale 1ns/1ns

module minesweeper_setup_tb import ms_pkg::*; ();

    localparam int CFG_WAIT   = 20;                  // Cycles allowed for cfg_valid
    localparam int PLACE_WAIT = 5000;                // Cycles allowed for placement

    logic               clk;
    logic               rst;
    level_e             level;
    logic               query_valid;
    logic [CELL_W-1:0]  query_row;
    logic [CELL_W-1:0]  query_col;
    logic [4:0]         grid_n;
    logic [9:0]         board_size;
    logic [10:0]        board_xpos;
    logic [10:0]        board_ypos;
    logic [6:0]         cell_size;
    logic [MINE_W-1:0]  mine_count;
    logic               cfg_valid;
    logic               placing;
    logic               place_done;
    logic               result_valid;
    logic               is_mine;
    logic [COUNT_W-1:0] near_count;

    int errors;
    int checks;
    bit done_seen;                                   // Placement finished since reset
    bit mine_tb [GRID_MAX][GRID_MAX];                // Map read back from the DUT
    int near_tb [GRID_MAX][GRID_MAX];                // Expected neighbor counts
    int q_row[$];                                    // Pending query cells
    int q_col[$];

    // Level table, indexed by level code
    int grid_tab[4] = '{0, 8, 10, 16};
    int mine_tab[4] = '{0, 8, 20, 60};
    int cell_tab[4] = '{0, 50, 50, 40};

    minesweeper_setup #(.MAX_GRID(16), .LFSR_SEED(16'hACE1)) minesweeper_setup_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(negedge clk) begin
        if (rst) begin
            done_seen <= 1'b0;
        end else if (place_done) begin
            done_seen <= 1'b1;                       // Sticky, strobe may pass mid-task
        end
    end

    task automatic check_value(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic reset_dut();
        @(posedge clk);
        rst         <= 1'b1;
        level       <= LVL_NONE;
        query_valid <= 1'b0;
        repeat (3) @(posedge clk);                   // Three cycles in reset
        rst         <= 1'b0;
    endtask

    task automatic check_geometry(input level_e lv);
        int size;
        size = grid_tab[lv] * cell_tab[lv];          // Square board
        check_value("grid_n", int'(grid_n), grid_tab[lv]);
        check_value("mine_count", int'(mine_count), mine_tab[lv]);
        check_value("board_size", int'(board_size), size);
        check_value("board_xpos", int'(board_xpos), (1440 - size) / 2);  // Centred in 1440x900
        check_value("board_ypos", int'(board_ypos), (900 - size) / 2);
        check_value("cell_size", int'(cell_size), cell_tab[lv]);
    endtask

    // Back to back queries, result expected on the following cycle
    task automatic issue_queries(input bit learn);
        int total;
        int r;
        int c;
        total = q_row.size();
        for (int idx = 0; idx <= total; idx++) begin
            @(posedge clk);
            if (idx < total) begin
                query_valid <= 1'b1;
                query_row   <= CELL_W'(q_row[idx]);
                query_col   <= CELL_W'(q_col[idx]);
            end else begin
                query_valid <= 1'b0;
            end
            @(negedge clk);
            if (idx == 0) begin
                check_value("result_valid", int'(result_valid), 0);  // Nothing in flight yet
            end else begin
                r = q_row[idx-1];
                c = q_col[idx-1];
                check_value("result_valid", int'(result_valid), 1);
                if (learn) begin
                    mine_tb[r][c] = is_mine;
                end else begin
                    check_value("is_mine", int'(is_mine), int'(mine_tb[r][c]));
                    check_value("near_count", int'(near_count), near_tb[r][c]);
                end
            end
        end
        @(negedge clk);
        check_value("result_valid", int'(result_valid), 0);  // No extra strobe
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        check_value("cfg_valid", int'(cfg_valid), 0);
        check_value("placing", int'(placing), 0);
        check_value("place_done", int'(place_done), 0);
        check_value("result_valid", int'(result_valid), 0);
        check_value("grid_n", int'(grid_n), 0);
        check_value("mine_count", int'(mine_count), 0);
        check_value("board_size", int'(board_size), 0);
        check_value("board_xpos", int'(board_xpos), 0);
        check_value("board_ypos", int'(board_ypos), 0);
        check_value("cell_size", int'(cell_size), 0);
    endtask

    task automatic check_level_table(input level_e lv, output bit ok);
        int waited;
        waited = 0;
        ok = 1'b1;
        @(posedge clk);
        level <= lv;
        @(negedge clk);
        while (!cfg_valid && waited < CFG_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!cfg_valid) begin
            errors++;
            $display("cfg_valid never arrived for level %s", lv.name());
            ok = 1'b0;
            return;
        end
        check_geometry(lv);
    endtask

    task automatic check_lock(input level_e lv);
        int other;
        other = (int'(lv) - 1 + int'($urandom_range(2, 1))) % 3 + 1;  // Another nonzero level
        @(posedge clk);
        level <= level_e'(2'(other));
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            if (i == 0) begin
                check_value("placing", int'(placing), 1);  // Raised by the strobe
            end
            check_value("cfg_valid", int'(cfg_valid), 0);
            check_geometry(lv);                      // Still the first choice
        end
    endtask

    task automatic check_mine_count(input level_e lv, output bit ok);
        int waited;
        int n;
        int total;
        n = grid_tab[lv];
        waited = 0;
        total = 0;
        ok = 1'b1;
        while (!done_seen && waited < PLACE_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!done_seen) begin
            errors++;
            $display("place_done never arrived for level %s", lv.name());
            ok = 1'b0;
            return;
        end
        check_value("placing", int'(placing), 0);
        q_row.delete();
        q_col.delete();
        for (int r = 0; r < n; r++) begin
            for (int c = 0; c < n; c++) begin
                q_row.push_back(r);
                q_col.push_back(c);
            end
        end
        issue_queries(1'b1);                         // Read the whole map back
        for (int r = 0; r < n; r++) begin
            for (int c = 0; c < n; c++) begin
                total += int'(mine_tb[r][c]);
            end
        end
        check_value("mines in grid", total, mine_tab[lv]);
    endtask

    task automatic check_neighbors(input int n);
        int sum;
        for (int r = 0; r < n; r++) begin
            for (int c = 0; c < n; c++) begin
                sum = 0;
                for (int y = r - 1; y <= r + 1; y++) begin
                    for (int x = c - 1; x <= c + 1; x++) begin
                        if ((y != r || x != c) && y >= 0 && x >= 0 && y < n && x < n) begin
                            sum += int'(mine_tb[y][x]);
                        end
                    end
                end
                near_tb[r][c] = sum;
            end
        end
        q_row.delete();
        q_col.delete();
        for (int r = 0; r < n; r++) begin
            for (int c = 0; c < n; c++) begin
                q_row.push_back(r);
                q_col.push_back(c);
            end
        end
        repeat (24) begin                            // Random revisits
            q_row.push_back(int'($urandom_range(n - 1)));
            q_col.push_back(int'($urandom_range(n - 1)));
        end
        issue_queries(1'b0);
    endtask

    initial begin
        level_e lv;
        bit     ok;
        void'($urandom(32'h8a00));
        rst         = 1'b1;
        level       = LVL_NONE;
        query_valid = 1'b0;
        query_row   = '0;
        query_col   = '0;
        errors      = 0;
        checks      = 0;
        for (int i = 1; i <= 3; i++) begin
            lv = level_e'(2'(i));
            reset_dut();                             // Level is only released by rst
            check_reset_state();
            check_level_table(lv, ok);
            if (ok) begin
                check_lock(lv);
                check_mine_count(lv, ok);
            end
            if (ok) begin
                check_neighbors(grid_tab[lv]);
            end
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* minesweeper_setup.f */
verilog/ms_pkg.sv
verilog/select_level.sv
verilog/mine_placer.sv
verilog/neighbor_counter.sv
verilog/minesweeper_setup.sv
test/minesweeper_setup_tb.sv

/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module minesweeper_setup_tb \
		-f minesweeper_setup.f --Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	@if grep -q "Done: errors found" sim.log || ! grep -q "Done: no errors" sim.log; then \
		echo "Simulation FAILED"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log
